// File: list.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_if.sv
hw/pipeline_control.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/cpu.sv
tests/cpu_properties.sv
tests/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= build

SRCS := $(filter-out +%,$(shell cat list.f))
HDRS := $(wildcard hw/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS) $(HDRS)
	$(VERILATOR) --binary --assert --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f list.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_cpu.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 5 * 200;

    logic        clk = 1'b0;
    logic        reset_n = 1'b1;
    logic        inst_read;
    word_t       inst_addr;
    word_t       inst_data;
    logic        data_read;
    logic        data_write;
    word_t       data_addr;
    word_t       data_wdata;
    word_t       data_rdata;
    word_t       output_port;
    logic        output_valid;
    logic        is_halted;

    word_t       imem [256];
    word_t       dmem [256];
    int          prog_len;
    int          cycle_count = 0;
    logic [15:0] lfsr_state = 16'd29;
    word_t       model [`REG_COUNT];
    word_t       got_out [$];
    word_t       exp_out [$];
    logic [31:0] got_store [$];
    logic [31:0] exp_store [$];

    cpu i_dut (.*);

    always #10 clk = ~clk;

    // Word-addressed memories that answer only to their strobes
    assign inst_data  = inst_read ? imem[inst_addr[7:0]] : `NOP_INST;
    assign data_rdata = data_read ? dmem[data_addr[7:0]] : '0;

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_addr[7:0]] <= data_wdata;
        end
    end

    always @(negedge clk) begin
        if (output_valid) begin
            got_out.push_back(output_port);
        end
        if (data_write) begin
            got_store.push_back({data_addr, data_wdata});
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the processor did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            fail_run();
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic imm_t random_imm();
        imm_t value;
        int   n;
        value = '0;
        for (n = 0; n < 8; n++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
        end
        return value;
    endfunction

    function automatic word_t sext(input imm_t imm);
        return {{8{imm[7]}}, imm};
    endfunction

    function automatic word_t r_inst(input funct_t f, input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd);
        return {4'hf, rs, rt, rd, f};
    endfunction

    function automatic word_t i_inst(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                     input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t alu_model(input funct_t f, input word_t a, input word_t b);
        case (f)
            FN_ADD:  return a + b;
            FN_SUB:  return a - b;
            FN_AND:  return a & b;
            FN_ORR:  return a | b;
            FN_NOT:  return ~a;
            FN_SHL:  return {a[14:0], 1'b0};
            // Sign bit kept
            FN_SHR:  return {a[15], a[15:1]};
            default: return a;
        endcase
    endfunction

    task automatic clear_program();
        int i;
        for (i = 0; i < 256; i++) begin
            imem[8'(i)] = `NOP_INST | word_t'(8'(i));
            dmem[8'(i)] <= {8'(i), ~8'(i)};
        end
        prog_len = 0;
        got_out.delete();
        exp_out.delete();
        got_store.delete();
        exp_store.delete();
    endtask

    task automatic emit(input word_t inst);
        imem[8'(prog_len)] = inst;
        prog_len++;
    endtask

    task automatic check_idle();
        check_value("inst_read", word_t'(inst_read), 16'h0000);
        check_value("data_read", word_t'(data_read), 16'h0000);
        check_value("data_write", word_t'(data_write), 16'h0000);
        check_value("output_valid", word_t'(output_valid), 16'h0000);
        check_value("is_halted", word_t'(is_halted), 16'h0000);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #2;
            check_idle();
        end
        reset_n = 1'b0;
        // First cycle out of reset
        @(negedge clk);
        check_idle();
    endtask

    task automatic run_to_halt();
        apply_reset();
        while (is_halted !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_outputs();
        check_value("output count", word_t'(got_out.size()), word_t'(exp_out.size()));
        foreach (exp_out[i]) begin
            check_value("output_port", got_out[i], exp_out[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        clear_program();
        emit(r_inst(FN_HLT, 2'd0, 2'd0, 2'd0));
        run_to_halt();
        compare_outputs();
    endtask

    task automatic test_alu_chain();
        funct_t    ops [$] = '{FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_SHL, FN_SHR};
        imm_t      hi;
        imm_t      lo;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        int        k;
        clear_program();
        for (k = 0; k < `REG_COUNT; k++) begin
            hi = random_imm();
            lo = random_imm();
            rd = 2'(k);
            emit(i_inst(OP_LHI, 2'd0, rd, hi));
            emit(i_inst(OP_ADI, rd, rd, lo));
            model[rd] = {hi, 8'h00} + sext(lo);
        end
        // Each result feeds the next op and goes straight out
        for (k = 0; k < ops.size(); k++) begin
            rs = 2'(k);
            rt = 2'(k + 1);
            rd = 2'(k + 2);
            emit(r_inst(ops[k], rs, rt, rd));
            emit(r_inst(FN_WWD, rd, 2'd0, 2'd0));
            model[rd] = alu_model(ops[k], model[rs], model[rt]);
            exp_out.push_back(model[rd]);
        end
        emit(r_inst(FN_HLT, 2'd0, 2'd0, 2'd0));
        run_to_halt();
        compare_outputs();
    endtask

    task automatic test_memory();
        imm_t  hi;
        imm_t  lo;
        imm_t  delta;
        word_t v1;
        word_t v2;
        clear_program();
        hi    = random_imm();
        lo    = random_imm();
        delta = random_imm();
        v1    = {hi, 8'h00} + sext(lo);
        v2    = v1 + sext(delta);
        // Base address 0x10 in r0
        emit(i_inst(OP_LHI, 2'd0, 2'd0, 8'h00));
        emit(i_inst(OP_ADI, 2'd0, 2'd0, 8'h10));
        emit(i_inst(OP_LHI, 2'd0, 2'd1, hi));
        emit(i_inst(OP_ADI, 2'd1, 2'd1, lo));
        emit(i_inst(OP_SWD, 2'd0, 2'd1, 8'h02));
        emit(i_inst(OP_ADI, 2'd1, 2'd2, delta));
        emit(i_inst(OP_SWD, 2'd0, 2'd2, 8'hff));
        emit(i_inst(OP_LWD, 2'd0, 2'd3, 8'h02));
        emit(r_inst(FN_ADD, 2'd3, 2'd3, 2'd2));
        emit(r_inst(FN_WWD, 2'd2, 2'd0, 2'd0));
        emit(i_inst(OP_LWD, 2'd0, 2'd1, 8'hff));
        emit(r_inst(FN_WWD, 2'd1, 2'd0, 2'd0));
        emit(r_inst(FN_HLT, 2'd0, 2'd0, 2'd0));
        exp_store.push_back({16'h0012, v1});
        exp_store.push_back({16'h000f, v2});
        exp_out.push_back(v1 + v1);
        exp_out.push_back(v2);
        run_to_halt();
        check_value("store count", word_t'(got_store.size()), word_t'(exp_store.size()));
        foreach (exp_store[i]) begin
            check_value("data_addr", got_store[i][31:16], exp_store[i][31:16]);
            check_value("data_wdata", got_store[i][15:0], exp_store[i][15:0]);
        end
        compare_outputs();
    endtask

    task automatic test_branches();
        imm_t a;
        imm_t b;
        clear_program();
        a = random_imm();
        b = a + 8'd1;
        emit(i_inst(OP_LHI, 2'd0, 2'd0, a));
        emit(i_inst(OP_LHI, 2'd0, 2'd1, a));
        emit(i_inst(OP_LHI, 2'd0, 2'd2, b));
        // Taken BEQ at 3 lands on 6
        emit(i_inst(OP_BEQ, 2'd0, 2'd1, 8'd2));
        emit(r_inst(FN_WWD, 2'd2, 2'd0, 2'd0));
        emit(r_inst(FN_WWD, 2'd1, 2'd0, 2'd0));
        // Taken BNE at 6 lands on 8
        emit(i_inst(OP_BNE, 2'd0, 2'd2, 8'd1));
        emit(r_inst(FN_WWD, 2'd0, 2'd0, 2'd0));
        emit(i_inst(OP_BEQ, 2'd0, 2'd2, 8'd1));
        emit(r_inst(FN_WWD, 2'd1, 2'd0, 2'd0));
        emit(r_inst(FN_WWD, 2'd2, 2'd0, 2'd0));
        emit(r_inst(FN_HLT, 2'd0, 2'd0, 2'd0));
        exp_out.push_back({a, 8'h00});
        exp_out.push_back({b, 8'h00});
        run_to_halt();
        compare_outputs();
    endtask

    task automatic test_halt();
        imm_t v;
        clear_program();
        v = random_imm();
        emit(i_inst(OP_LHI, 2'd0, 2'd0, v));
        emit(r_inst(FN_WWD, 2'd0, 2'd0, 2'd0));
        emit(r_inst(FN_HLT, 2'd0, 2'd0, 2'd0));
        emit(r_inst(FN_WWD, 2'd0, 2'd0, 2'd0));
        emit(r_inst(FN_WWD, 2'd0, 2'd0, 2'd0));
        exp_out.push_back({v, 8'h00});
        run_to_halt();
        repeat (20) begin
            @(negedge clk);
            check_value("is_halted", word_t'(is_halted), 16'h0001);
            check_value("inst_read", word_t'(inst_read), 16'h0000);
        end
        compare_outputs();
    endtask

    initial begin
        test_reset();
        test_alu_chain();
        test_memory();
        test_branches();
        test_halt();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: tests/cpu_properties.sv
`timescale 1ns/100ps

module cpu_properties import cpu_pkg::*; (
    input logic  clk,
    input logic  reset_n,
    input logic  data_read,
    input logic  data_write,
    input logic  output_valid,
    input logic  is_halted,
    input word_t inst_addr
);

    // One data access per cycle
    a_single_access: assert property (@(posedge clk) disable iff (reset_n)
        !(data_read && data_write))
        else $error("data_read and data_write high in the same cycle");

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
        else $error("is_halted dropped before reset");

    a_no_output_halted: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |-> !output_valid)
        else $error("output_valid pulsed while halted");

    // Frozen program counter
    a_pc_frozen: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |-> $stable(inst_addr))
        else $error("inst_addr moved while halted");

endmodule

bind cpu cpu_properties i_properties (
    .clk          (clk),
    .reset_n      (reset_n),
    .data_read    (data_read),
    .data_write   (data_write),
    .output_valid (output_valid),
    .is_halted    (is_halted),
    .inst_addr    (inst_addr)
);

// File: hw/cpu.sv
`timescale 1ns/100ps

module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    output logic  inst_read,
    output word_t inst_addr,
    input  word_t inst_data,
    output logic  data_read,
    output logic  data_write,
    output word_t data_addr,
    output word_t data_wdata,
    input  word_t data_rdata,
    output word_t output_port,
    output logic  output_valid,
    output logic  is_halted
);

    word_t     if_inst;
    word_t     if_pc_plus1;
    word_t     branch_target;
    word_t     mem_result;
    logic      wb_write;
    reg_addr_t wb_dest;
    word_t     wb_data;

    hazard_if  haz ();
    decoded_if dec ();
    exec_if    exe ();

    pipeline_control i_control (
        .clk     (clk),
        .reset_n (reset_n),
        .haz     (haz)
    );

    fetch_stage i_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .haz           (haz),
        .inst_read     (inst_read),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .branch_target (branch_target),
        .if_inst       (if_inst),
        .if_pc_plus1   (if_pc_plus1)
    );

    decode_stage i_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .if_inst     (if_inst),
        .if_pc_plus1 (if_pc_plus1),
        .wb_write    (wb_write),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .haz         (haz),
        .dec         (dec)
    );

    execute_stage i_execute (
        .clk           (clk),
        .reset_n       (reset_n),
        .dec           (dec),
        .haz           (haz),
        .mem_result    (mem_result),
        .wb_data       (wb_data),
        .branch_target (branch_target),
        .exe           (exe)
    );

    memory_writeback i_mem_wb (
        .clk          (clk),
        .reset_n      (reset_n),
        .exe          (exe),
        .haz          (haz),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .mem_result   (mem_result),
        .wb_write     (wb_write),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

endmodule

// File: hw/memory_writeback.sv
`timescale 1ns/100ps

module memory_writeback import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    exec_if.sink       exe,
    hazard_if.writeback haz,
    output logic       data_read,
    output logic       data_write,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  word_t      data_rdata,
    output word_t      mem_result,
    output logic       wb_write,
    output reg_addr_t  wb_dest,
    output word_t      wb_data,
    output word_t      output_port,
    output logic       output_valid,
    output logic       is_halted
);

    // Same-cycle memory response
    assign data_read  = exe.mem_read;
    assign data_write = exe.mem_write;
    assign data_addr  = exe.result;
    assign data_wdata = exe.store_data;
    assign mem_result = exe.result;

    assign haz.mem_dest      = exe.dest;
    assign haz.mem_reg_write = exe.reg_write;
    assign haz.wb_dest       = wb_dest;
    assign haz.wb_reg_write  = wb_write;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_write     <= 1'b0;
            output_valid <= 1'b0;
            is_halted    <= 1'b0;
        end else begin
            wb_write     <= exe.reg_write;
            output_valid <= exe.wwd;
            if (exe.halt) begin
                is_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= exe.dest;
        wb_data <= exe.mem_read ? data_rdata : exe.result;
        if (exe.wwd) begin
            output_port <= exe.result;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    decoded_if.sink  dec,
    hazard_if.execute haz,
    input  word_t    mem_result,
    input  word_t    wb_data,
    output word_t    branch_target,
    exec_if.source   exe
);

    word_t a;
    word_t b_reg;
    word_t b;
    word_t alu_out;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign a     = fwd_mux(haz.fwd_a, dec.rs_val, mem_result, wb_data);
    assign b_reg = fwd_mux(haz.fwd_b, dec.rt_val, mem_result, wb_data);
    // Immediate forms take the extended immediate as operand b
    assign b     = (dec.op == OP_RTYPE) ? b_reg : dec.imm;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_out = a + b;
            ALU_SUB: alu_out = a - b;
            ALU_AND: alu_out = a & b;
            ALU_OR:  alu_out = a | b;
            ALU_NOT: alu_out = ~a;
            ALU_SHL: alu_out = a << 1;
            // Arithmetic shift, sign bit kept
            ALU_SHR: alu_out = word_t'($signed(a) >>> 1);
            default: alu_out = b;
        endcase
    end

    assign haz.branch_taken = dec.is_branch && ((a == b_reg) == dec.branch_eq);
    assign branch_target    = dec.pc_plus1 + dec.imm;

    assign haz.ex_dest      = dec.dest;
    assign haz.ex_reg_write = dec.reg_write;
    assign haz.ex_is_load   = dec.mem_read;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset_n) begin
            exe.reg_write <= 1'b0;
            exe.mem_read  <= 1'b0;
            exe.mem_write <= 1'b0;
            exe.wwd       <= 1'b0;
            exe.halt      <= 1'b0;
        end else begin
            exe.reg_write <= dec.reg_write;
            exe.mem_read  <= dec.mem_read;
            exe.mem_write <= dec.mem_write;
            exe.wwd       <= dec.wwd;
            exe.halt      <= dec.halt;
        end
    end

    always_ff @(posedge clk) begin
        // WWD carries rs to the output port
        exe.result     <= dec.wwd ? a : alu_out;
        exe.store_data <= b_reg;
        exe.dest       <= dec.dest;
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  word_t     if_inst,
    input  word_t     if_pc_plus1,
    input  logic      wb_write,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    hazard_if.decode  haz,
    decoded_if.source dec
);

    word_t     regs [`REG_COUNT];
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    word_t     imm_ext;
    word_t     rs_val;
    word_t     rt_val;
    alu_op_t   alu_op;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_eq;
    logic      wwd;
    logic      halt;
    logic      uses_rs;
    logic      uses_rt;
    logic      bubble;

    assign opcode = opcode_t'(if_inst[15:12]);
    assign rs     = if_inst[11:10];
    assign rt     = if_inst[9:8];
    assign rd     = if_inst[7:6];
    assign funct  = funct_t'(if_inst[5:0]);
    assign imm    = if_inst[7:0];

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        dest      = rt;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        branch_eq = 1'b0;
        wwd       = 1'b0;
        halt      = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        imm_ext   = {{(`WORD_SIZE-8){imm[7]}}, imm};
        case (opcode)
            OP_RTYPE: begin
                dest = rd;
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        reg_write = 1'b1;
                        uses_rs   = 1'b1;
                        uses_rt   = 1'b1;
                    end
                    FN_NOT, FN_SHL, FN_SHR: begin
                        reg_write = 1'b1;
                        uses_rs   = 1'b1;
                    end
                    FN_WWD: begin
                        wwd     = 1'b1;
                        uses_rs = 1'b1;
                    end
                    FN_HLT: halt = 1'b1;
                    default: ;
                endcase
                case (funct)
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_ORR: alu_op = ALU_OR;
                    FN_NOT: alu_op = ALU_NOT;
                    FN_SHL: alu_op = ALU_SHL;
                    FN_SHR: alu_op = ALU_SHR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ADI: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            OP_LHI: begin
                alu_op    = ALU_PASS_B;
                reg_write = 1'b1;
                imm_ext   = {imm, 8'h00};
            end
            OP_LWD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                uses_rs   = 1'b1;
            end
            OP_SWD: begin
                mem_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                branch_eq = opcode == OP_BEQ;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            default: ;
        endcase
    end

    assign haz.id_rs      = rs;
    assign haz.id_rt      = rt;
    assign haz.id_uses_rs = uses_rs;
    assign haz.id_uses_rt = uses_rt;
    assign haz.id_is_halt = halt;

    // Register file, writeback value visible in the same cycle
    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_dest] <= wb_data;
        end
    end

    assign rs_val = (wb_write && wb_dest == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_write && wb_dest == rt) ? wb_data : regs[rt];

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX
    ////////////////////////////////////////////////////////////////////////////

    assign bubble = haz.stall || haz.flush;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            dec.reg_write <= 1'b0;
            dec.mem_read  <= 1'b0;
            dec.mem_write <= 1'b0;
            dec.is_branch <= 1'b0;
            dec.wwd       <= 1'b0;
            dec.halt      <= 1'b0;
        end else begin
            dec.reg_write <= reg_write && !bubble;
            dec.mem_read  <= mem_read && !bubble;
            dec.mem_write <= mem_write && !bubble;
            dec.is_branch <= is_branch && !bubble;
            dec.wwd       <= wwd && !bubble;
            dec.halt      <= halt && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        dec.op        <= opcode;
        dec.alu_op    <= alu_op;
        dec.rs_val    <= rs_val;
        dec.rt_val    <= rt_val;
        dec.imm       <= imm_ext;
        dec.dest      <= dest;
        dec.branch_eq <= branch_eq;
        dec.pc_plus1  <= if_pc_plus1;
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    hazard_if.fetch haz,
    output logic  inst_read,
    output word_t inst_addr,
    input  word_t inst_data,
    input  word_t branch_target,
    output word_t if_inst,
    output word_t if_pc_plus1
);

    word_t pc;
    word_t pc_plus1;
    logic  run_q;

    assign pc_plus1  = pc + 1'b1;
    assign inst_addr = pc;
    // Idle for one cycle after reset
    assign inst_read = run_q && !haz.freeze;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc      <= `RESET_PC;
            run_q   <= 1'b0;
            if_inst <= `NOP_INST;
        end else begin
            run_q <= 1'b1;
            if (haz.flush) begin
                pc      <= branch_target;
                if_inst <= `NOP_INST;
            end else if (haz.freeze) begin
                if_inst <= `NOP_INST;
            end else if (run_q && !haz.stall) begin
                pc      <= pc_plus1;
                if_inst <= inst_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!haz.stall) begin
            if_pc_plus1 <= pc_plus1;
        end
    end

endmodule

// File: hw/pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control import cpu_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    hazard_if.control haz
);

    // Sources of the instruction now in execute
    reg_addr_t ex_rs_q;
    reg_addr_t ex_rt_q;
    logic      ex_uses_rs_q;
    logic      ex_uses_rt_q;
    logic      freeze_q;
    logic      rs_hit;
    logic      rt_hit;

    function automatic fwd_sel_t pick_src(
        input logic      uses,
        input reg_addr_t src,
        input logic      mem_wr,
        input reg_addr_t mem_dst,
        input logic      wb_wr,
        input reg_addr_t wb_dst
    );
        // Memory stage holds the younger value
        if (uses && mem_wr && mem_dst == src) begin
            return FWD_MEM;
        end
        if (uses && wb_wr && wb_dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign rs_hit = haz.id_uses_rs && haz.id_rs == haz.ex_dest;
    assign rt_hit = haz.id_uses_rt && haz.id_rt == haz.ex_dest;

    // Load-use, one bubble
    assign haz.stall  = haz.ex_is_load && haz.ex_reg_write && (rs_hit || rt_hit);
    assign haz.flush  = haz.branch_taken;
    assign haz.freeze = freeze_q || (haz.id_is_halt && !haz.flush);

    assign haz.fwd_a = pick_src(ex_uses_rs_q, ex_rs_q, haz.mem_reg_write, haz.mem_dest,
                                haz.wb_reg_write, haz.wb_dest);
    assign haz.fwd_b = pick_src(ex_uses_rt_q, ex_rt_q, haz.mem_reg_write, haz.mem_dest,
                                haz.wb_reg_write, haz.wb_dest);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_rs_q      <= '0;
            ex_rt_q      <= '0;
            ex_uses_rs_q <= 1'b0;
            ex_uses_rt_q <= 1'b0;
            freeze_q     <= 1'b0;
        end else begin
            ex_rs_q      <= haz.id_rs;
            ex_rt_q      <= haz.id_rt;
            // Bubble in ID/EX reads nothing
            ex_uses_rs_q <= haz.id_uses_rs && !haz.stall && !haz.flush;
            ex_uses_rt_q <= haz.id_uses_rt && !haz.stall && !haz.flush;
            freeze_q     <= haz.freeze;
        end
    end

endmodule

// File: hw/cpu_if.sv
`timescale 1ns/100ps

////////////////////////////////////////////////////////////////////////////
// Hazard and forwarding traffic between the stages and pipeline control
////////////////////////////////////////////////////////////////////////////

interface hazard_if import cpu_pkg::*; ();
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    logic      id_uses_rs;
    logic      id_uses_rt;
    logic      id_is_halt;
    reg_addr_t ex_dest;
    logic      ex_reg_write;
    logic      ex_is_load;
    logic      branch_taken;
    reg_addr_t mem_dest;
    logic      mem_reg_write;
    reg_addr_t wb_dest;
    logic      wb_reg_write;
    logic      stall;
    logic      flush;
    logic      freeze;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;

    modport control (
        input  id_rs, id_rt, id_uses_rs, id_uses_rt, id_is_halt,
        input  ex_dest, ex_reg_write, ex_is_load, branch_taken,
        input  mem_dest, mem_reg_write, wb_dest, wb_reg_write,
        output stall, flush, freeze, fwd_a, fwd_b
    );
    modport fetch (input stall, flush, freeze);
    modport decode (
        output id_rs, id_rt, id_uses_rs, id_uses_rt, id_is_halt,
        input  stall, flush
    );
    modport execute (
        output ex_dest, ex_reg_write, ex_is_load, branch_taken,
        input  fwd_a, fwd_b
    );
    modport writeback (output mem_dest, mem_reg_write, wb_dest, wb_reg_write);
endinterface

// ID/EX register
interface decoded_if import cpu_pkg::*; ();
    opcode_t   op;
    alu_op_t   alu_op;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_eq;
    logic      wwd;
    logic      halt;
    word_t     pc_plus1;

    modport source (
        output op, alu_op, rs_val, rt_val, imm, dest, reg_write, mem_read,
        output mem_write, is_branch, branch_eq, wwd, halt, pc_plus1
    );
    modport sink (
        input  op, alu_op, rs_val, rt_val, imm, dest, reg_write, mem_read,
        input  mem_write, is_branch, branch_eq, wwd, halt, pc_plus1
    );
endinterface

// EX/MEM register
interface exec_if import cpu_pkg::*; ();
    word_t     result;
    word_t     store_data;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      wwd;
    logic      halt;

    modport source (
        output result, store_data, dest, reg_write, mem_read, mem_write, wwd, halt
    );
    modport sink (
        input  result, store_data, dest, reg_write, mem_read, mem_write, wwd, halt
    );
endinterface

// File: hw/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;
    typedef logic [7:0] imm_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_B
    } alu_op_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and address width
`define WORD_SIZE 16

`define REG_COUNT 4

// First fetch address after reset
`define RESET_PC 16'h0000

// Unused opcode 11, decodes to an instruction with no effect
`define NOP_INST 16'hb000

`endif
